//--- hw/icache_align.sv
`timescale 1ns/1ps

module icache_align (
  // bit 1 marks the last word of the line, bit 0 the upper halfword
  input  logic [1:0]                   offset_i,
  input  logic [icache_pkg::XLEN-1:0]  word_i,
  input  logic [icache_pkg::XLEN-1:0]  next_word_i,
  output logic [icache_pkg::XLEN-1:0]  inst_o,
  output logic                         cross_line_o
);

  logic [15:0]                 cur_half;
  logic [15:0]                 upper_half;
  logic                        is_32;
  logic [icache_pkg::XLEN-1:0] raw;

  // halfword the fetch points at
  assign cur_half = offset_i[0] ? word_i[31:16] : word_i[15:0];

  // following halfword, from the next word when starting in the upper half
  assign upper_half = offset_i[0] ? next_word_i[15:0] : word_i[31:16];

  // rvc: low bits 11 mean a full 32-bit encoding
  assign is_32 = (cur_half[1:0] == 2'b11);

  // compressed form is zero-extended
  assign raw = is_32 ? {upper_half, cur_half} : {16'h0000, cur_half};

  // all-zero word is an illegal encoding, hand out a nop instead
  assign inst_o = (raw == '0) ? icache_pkg::NOP_INST : raw;

  // starts at byte 62, upper half lives in the next line
  assign cross_line_o = is_32 && offset_i[0] && offset_i[1];

endmodule

//--- hw/icache_csr.sv
`timescale 1ns/1ps

module icache_csr (
  input  logic                               clk,
  input  logic                               rst,
  // zero-wait apb slave
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [icache_pkg::CSR_ADDR_W-1:0]  paddr_i,
  input  logic [icache_pkg::XLEN-1:0]        pwdata_i,
  output logic [icache_pkg::XLEN-1:0]        prdata_o,
  // events from the controller
  input  logic                               hit_pulse_i,
  input  logic                               miss_pulse_i,
  input  logic                               flush_ack_i,
  output logic                               flush_req_o,
  output logic [icache_pkg::XLEN-1:0]        unc_base_o,
  output logic [icache_pkg::XLEN-1:0]        unc_mask_o
);

  logic                        wr_acc;
  logic [icache_pkg::XLEN-1:0] hit_cnt_q;
  logic [icache_pkg::XLEN-1:0] miss_cnt_q;

  // write lands in the access phase
  assign wr_acc = psel_i && penable_i && pwrite_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      unc_base_o  <= icache_pkg::UNC_BASE_RST;
      unc_mask_o  <= icache_pkg::UNC_MASK_RST;
      flush_req_o <= 1'b0;
      hit_cnt_q   <= '0;
      miss_cnt_q  <= '0;
    end else begin
      // pending flush clears once the controller takes it in idle
      if (flush_ack_i) begin
        flush_req_o <= 1'b0;
      end
      if (wr_acc) begin
        case (icache_pkg::csr_reg_e'(paddr_i))
          icache_pkg::CTRL: begin
            if (pwdata_i[0]) begin
              flush_req_o <= 1'b1;
            end
          end
          icache_pkg::UNC_BASE: unc_base_o <= pwdata_i;
          icache_pkg::UNC_MASK: unc_mask_o <= pwdata_i;
          default: ;
        endcase
      end
      // free running, wrap at 2^32
      hit_cnt_q  <= hit_cnt_q + {31'd0, hit_pulse_i};
      miss_cnt_q <= miss_cnt_q + {31'd0, miss_pulse_i};
    end
  end

  // read mux, ctrl reads back zero
  always_comb begin
    case (icache_pkg::csr_reg_e'(paddr_i))
      icache_pkg::UNC_BASE: prdata_o = unc_base_o;
      icache_pkg::UNC_MASK: prdata_o = unc_mask_o;
      icache_pkg::HIT_CNT:  prdata_o = hit_cnt_q;
      icache_pkg::MISS_CNT: prdata_o = miss_cnt_q;
      default:              prdata_o = '0;
    endcase
  end

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                                 clk,
  input  logic                                 rst,
  // fetch side
  input  logic                                 fetch_valid_i,
  input  logic [icache_pkg::XLEN-1:0]          fetch_addr_i,
  output logic                                 fetch_rvalid_o,
  output logic [icache_pkg::XLEN-1:0]          fetch_rdata_o,
  // memory side
  output logic                                 mem_req_valid_o,
  output logic [icache_pkg::XLEN-1:0]          mem_addr_o,
  output logic [7:0]                           mem_len_o,
  input  logic                                 mem_rvalid_i,
  input  logic [icache_pkg::XLEN-1:0]          mem_rdata_i,
  // tag array
  output logic [icache_pkg::INDEX_W-1:0]       cur_index_o,
  output logic [icache_pkg::TAG_W-1:0]         cur_tag_o,
  output logic [icache_pkg::INDEX_W-1:0]       next_index_o,
  output logic [icache_pkg::TAG_W-1:0]         next_tag_o,
  input  logic                                 cur_hit_i,
  input  logic                                 next_hit_i,
  // data array
  output logic [icache_pkg::WORD_ADDR_W-1:0]   rd_word_addr_o,
  output logic                                 wr_en_o,
  output logic [icache_pkg::INDEX_W-1:0]       wr_index_o,
  output logic [icache_pkg::WORD_SEL_W-1:0]    wr_word_o,
  output logic [icache_pkg::TAG_W-1:0]         wr_tag_o,
  // aligner
  output logic [1:0]                           lookup_offset_o,
  input  logic [icache_pkg::XLEN-1:0]          inst_i,
  input  logic                                 cross_line_i,
  // configuration block
  input  logic [icache_pkg::XLEN-1:0]          unc_base_i,
  input  logic [icache_pkg::XLEN-1:0]          unc_mask_i,
  input  logic                                 flush_req_i,
  output logic                                 flush_o,
  output logic                                 hit_pulse_o,
  output logic                                 miss_pulse_o
);

  icache_pkg::icache_state_e            state_q;
  logic [icache_pkg::XLEN-1:0]          addr_q;
  logic [icache_pkg::WORD_SEL_W-1:0]    beat_q;
  logic                                 rvalid_q;
  logic                                 unc_sel_q;
  logic [icache_pkg::XLEN-1:0]          unc_word_q;

  logic [icache_pkg::WORD_SEL_W-1:0]    word_sel;
  logic [icache_pkg::TAG_W+icache_pkg::INDEX_W-1:0] next_line;
  logic                                 in_lookup;
  logic                                 in_refill;
  logic                                 accept;
  logic                                 uncached;
  logic                                 need_next;
  logic                                 take_miss;
  logic                                 take_next;

  // fields of the registered request
  assign cur_tag_o   = addr_q[icache_pkg::XLEN-1 -: icache_pkg::TAG_W];
  assign cur_index_o = addr_q[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign word_sel    = addr_q[2 +: icache_pkg::WORD_SEL_W];

  // line after the demand line, carries into the tag at the top index
  assign next_line    = {cur_tag_o, cur_index_o} + 1'b1;
  assign next_tag_o   = next_line[icache_pkg::INDEX_W +: icache_pkg::TAG_W];
  assign next_index_o = next_line[icache_pkg::INDEX_W-1:0];

  // aligner gets {last word of line, upper halfword of word}
  assign rd_word_addr_o  = {cur_index_o, word_sel};
  assign lookup_offset_o = {word_sel == icache_pkg::WORD_SEL_W'(icache_pkg::LINE_WORDS - 1),
                            addr_q[1]};

  assign in_lookup = (state_q == icache_pkg::LOOKUP);
  assign in_refill = (state_q == icache_pkg::MISS) || (state_q == icache_pkg::NEXT_REFILL);

  // flush has priority, and the returning request is not taken twice
  assign flush_o = (state_q == icache_pkg::IDLE) && flush_req_i;
  assign accept  = (state_q == icache_pkg::IDLE) && fetch_valid_i && !rvalid_q && !flush_req_i;

  // lookup decision
  assign uncached  = (addr_q & unc_mask_i) == unc_base_i;
  assign need_next = cross_line_i && !next_hit_i;
  assign take_miss = !uncached && !cur_hit_i;
  assign take_next = !uncached && cur_hit_i && need_next;

  assign hit_pulse_o  = in_lookup && !uncached && cur_hit_i && !need_next;
  assign miss_pulse_o = in_lookup && (take_miss || take_next);

  // refill write, one word per beat
  assign wr_en_o    = in_refill && mem_rvalid_i;
  assign wr_word_o  = beat_q;
  assign wr_index_o = (state_q == icache_pkg::NEXT_REFILL) ? next_index_o : cur_index_o;
  assign wr_tag_o   = (state_q == icache_pkg::NEXT_REFILL) ? next_tag_o : cur_tag_o;

  // cached data stays valid in the return cycle since addr_q is still held
  assign fetch_rvalid_o = rvalid_q;
  assign fetch_rdata_o  = unc_sel_q ? unc_word_q : inst_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= icache_pkg::RESET;
      beat_q          <= '0;
      rvalid_q        <= 1'b0;
      unc_sel_q       <= 1'b0;
      mem_req_valid_o <= 1'b0;
      mem_len_o       <= '0;
    end else begin
      rvalid_q <= 1'b0;
      case (state_q)
        icache_pkg::RESET: state_q <= icache_pkg::IDLE;
        icache_pkg::IDLE: begin
          if (accept) begin
            state_q <= icache_pkg::LOOKUP;
          end
        end
        icache_pkg::LOOKUP: begin
          beat_q <= '0;
          if (uncached) begin
            // single word, no burst
            state_q         <= icache_pkg::UNCACHED;
            mem_req_valid_o <= 1'b1;
            mem_len_o       <= 8'd0;
          end else if (take_miss) begin
            state_q         <= icache_pkg::MISS;
            mem_req_valid_o <= 1'b1;
            mem_len_o       <= 8'(icache_pkg::BURST_LAST);
          end else if (take_next) begin
            // upper half of the instruction sits in the next line
            state_q         <= icache_pkg::NEXT_REFILL;
            mem_req_valid_o <= 1'b1;
            mem_len_o       <= 8'(icache_pkg::BURST_LAST);
          end else begin
            state_q   <= icache_pkg::IDLE;
            rvalid_q  <= 1'b1;
            unc_sel_q <= 1'b0;
          end
        end
        icache_pkg::MISS, icache_pkg::NEXT_REFILL: begin
          if (mem_rvalid_i) begin
            beat_q <= beat_q + 1'b1;
            // last beat, go back and repeat the lookup
            if (beat_q == icache_pkg::WORD_SEL_W'(icache_pkg::BURST_LAST)) begin
              mem_req_valid_o <= 1'b0;
              state_q         <= icache_pkg::IDLE;
            end
          end
        end
        icache_pkg::UNCACHED: begin
          if (mem_rvalid_i) begin
            mem_req_valid_o <= 1'b0;
            rvalid_q        <= 1'b1;
            unc_sel_q       <= 1'b1;
            state_q         <= icache_pkg::IDLE;
          end
        end
        default: state_q <= icache_pkg::IDLE;
      endcase
    end
  end

  // request address, memory address and uncached word
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
    if (in_lookup) begin
      if (uncached) begin
        mem_addr_o <= {addr_q[icache_pkg::XLEN-1:2], 2'b00};
      end else if (take_miss) begin
        mem_addr_o <= {cur_tag_o, cur_index_o, {icache_pkg::OFFSET_W{1'b0}}};
      end else if (take_next) begin
        mem_addr_o <= {next_line, {icache_pkg::OFFSET_W{1'b0}}};
      end
    end
    if (state_q == icache_pkg::UNCACHED && mem_rvalid_i) begin
      unc_word_q <= mem_rdata_i;
    end
  end

endmodule

//--- hw/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array (
  input  logic                                clk,
  // refill write port, one beat per cycle
  input  logic                                wr_en_i,
  input  logic [icache_pkg::INDEX_W-1:0]      wr_index_i,
  input  logic [icache_pkg::WORD_SEL_W-1:0]   wr_word_i,
  input  logic [icache_pkg::XLEN-1:0]         wr_data_i,
  // combinational read of two consecutive words
  input  logic [icache_pkg::WORD_ADDR_W-1:0]  rd_word_addr_i,
  output logic [icache_pkg::XLEN-1:0]         rd_word_o,
  output logic [icache_pkg::XLEN-1:0]         rd_next_word_o
);

  logic [icache_pkg::XLEN-1:0]        mem [icache_pkg::DATA_WORDS];
  logic [icache_pkg::WORD_ADDR_W-1:0] wr_addr;
  logic [icache_pkg::WORD_ADDR_W-1:0] rd_next_addr;

  // line index picks the row of 16 words
  assign wr_addr = {wr_index_i, wr_word_i};

  // word 15 rolls into word 0 of the next line
  // top line rolls back to line 0
  assign rd_next_addr = rd_word_addr_i + 1'b1;

  assign rd_word_o      = mem[rd_word_addr_i];
  assign rd_next_word_o = mem[rd_next_addr];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr] <= wr_data_i;
    end
  end

endmodule

//--- hw/icache_pkg.sv
package icache_pkg;

  // address and data width
  localparam int XLEN = 32;

  // address split: tag | index | offset
  localparam int OFFSET_W = 6;
  localparam int INDEX_W = 7;
  localparam int TAG_W = XLEN - INDEX_W - OFFSET_W;

  // word select inside a 64 byte line
  localparam int WORD_SEL_W = 4;
  localparam int LINE_WORDS = 16;
  localparam int BURST_LAST = LINE_WORDS - 1;

  // flat word store, index and word select concatenated
  localparam int WORD_ADDR_W = INDEX_W + WORD_SEL_W;
  localparam int DATA_WORDS = 1 << WORD_ADDR_W;
  localparam int LINES = 1 << INDEX_W;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

  // default uncached window 0xA0000000 .. 0xAFFFFFFF
  localparam logic [XLEN-1:0] UNC_BASE_RST = 32'hA000_0000;
  localparam logic [XLEN-1:0] UNC_MASK_RST = 32'hF000_0000;

  localparam int CSR_ADDR_W = 5;

  // controller states
  typedef enum logic [2:0] {
    RESET,
    IDLE,
    LOOKUP,
    MISS,
    NEXT_REFILL,
    UNCACHED
  } icache_state_e;

  // apb register map
  typedef enum logic [CSR_ADDR_W-1:0] {
    CTRL     = 5'h00,
    UNC_BASE = 5'h04,
    UNC_MASK = 5'h08,
    HIT_CNT  = 5'h0C,
    MISS_CNT = 5'h10
  } csr_reg_e;

endpackage

//--- hw/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array (
  input  logic                            clk,
  input  logic                            rst,
  // demand line lookup
  input  logic [icache_pkg::INDEX_W-1:0]  cur_index_i,
  input  logic [icache_pkg::TAG_W-1:0]    cur_tag_i,
  // next line lookup for line-crossing instructions
  input  logic [icache_pkg::INDEX_W-1:0]  next_index_i,
  input  logic [icache_pkg::TAG_W-1:0]    next_tag_i,
  // refill write
  input  logic                            wr_en_i,
  input  logic [icache_pkg::INDEX_W-1:0]  wr_index_i,
  input  logic [icache_pkg::TAG_W-1:0]    wr_tag_i,
  input  logic                            flush_i,
  output logic                            cur_hit_o,
  output logic                            next_hit_o
);

  logic [icache_pkg::LINES-1:0] valid_q;
  logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::LINES];

  assign cur_hit_o  = valid_q[cur_index_i] && (tag_mem[cur_index_i] == cur_tag_i);
  assign next_hit_o = valid_q[next_index_i] && (tag_mem[next_index_i] == next_tag_i);

  // valid bits cleared by reset and fence.i flush
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[wr_index_i] <= 1'b1;
    end
  end

  // rewritten each beat, settles on the last one
  // no lookup runs until the burst ends
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      tag_mem[wr_index_i] <= wr_tag_i;
    end
  end

endmodule

//--- hw/icache_top.sv
`timescale 1ns/1ps

module icache_top (
  input  logic                                clk,
  input  logic                                rst,
  // fetch side
  input  logic                                fetch_valid_i,
  input  logic [icache_pkg::XLEN-1:0]         fetch_addr_i,
  output logic                                fetch_rvalid_o,
  output logic [icache_pkg::XLEN-1:0]         fetch_rdata_o,
  // memory side
  output logic                                mem_req_valid_o,
  output logic [icache_pkg::XLEN-1:0]         mem_addr_o,
  output logic [7:0]                          mem_len_o,
  input  logic                                mem_rvalid_i,
  input  logic [icache_pkg::XLEN-1:0]         mem_rdata_i,
  // apb configuration
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [icache_pkg::CSR_ADDR_W-1:0]   paddr_i,
  input  logic [icache_pkg::XLEN-1:0]         pwdata_i,
  output logic [icache_pkg::XLEN-1:0]         prdata_o
);

  // tag lookup
  logic [icache_pkg::INDEX_W-1:0]     cur_index;
  logic [icache_pkg::TAG_W-1:0]       cur_tag;
  logic [icache_pkg::INDEX_W-1:0]     next_index;
  logic [icache_pkg::TAG_W-1:0]       next_tag;
  logic                               cur_hit;
  logic                               next_hit;

  // refill write path
  logic                               wr_en;
  logic [icache_pkg::INDEX_W-1:0]     wr_index;
  logic [icache_pkg::WORD_SEL_W-1:0]  wr_word;
  logic [icache_pkg::TAG_W-1:0]       wr_tag;

  // read and align
  logic [icache_pkg::WORD_ADDR_W-1:0] rd_word_addr;
  logic [icache_pkg::XLEN-1:0]        rd_word;
  logic [icache_pkg::XLEN-1:0]        rd_next_word;
  logic [1:0]                         lookup_offset;
  logic [icache_pkg::XLEN-1:0]        inst;
  logic                               cross_line;

  // configuration
  logic [icache_pkg::XLEN-1:0]        unc_base;
  logic [icache_pkg::XLEN-1:0]        unc_mask;
  logic                               flush_req;
  logic                               flush;
  logic                               hit_pulse;
  logic                               miss_pulse;

  icache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_rvalid_o  (fetch_rvalid_o),
    .fetch_rdata_o   (fetch_rdata_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_addr_o      (mem_addr_o),
    .mem_len_o       (mem_len_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .cur_index_o     (cur_index),
    .cur_tag_o       (cur_tag),
    .next_index_o    (next_index),
    .next_tag_o      (next_tag),
    .cur_hit_i       (cur_hit),
    .next_hit_i      (next_hit),
    .rd_word_addr_o  (rd_word_addr),
    .wr_en_o         (wr_en),
    .wr_index_o      (wr_index),
    .wr_word_o       (wr_word),
    .wr_tag_o        (wr_tag),
    .lookup_offset_o (lookup_offset),
    .inst_i          (inst),
    .cross_line_i    (cross_line),
    .unc_base_i      (unc_base),
    .unc_mask_i      (unc_mask),
    .flush_req_i     (flush_req),
    .flush_o         (flush),
    .hit_pulse_o     (hit_pulse),
    .miss_pulse_o    (miss_pulse)
  );

  icache_tag_array u_tag (
    .clk          (clk),
    .rst          (rst),
    .cur_index_i  (cur_index),
    .cur_tag_i    (cur_tag),
    .next_index_i (next_index),
    .next_tag_i   (next_tag),
    .wr_en_i      (wr_en),
    .wr_index_i   (wr_index),
    .wr_tag_i     (wr_tag),
    .flush_i      (flush),
    .cur_hit_o    (cur_hit),
    .next_hit_o   (next_hit)
  );

  icache_data_array u_data (
    .clk            (clk),
    .wr_en_i        (wr_en),
    .wr_index_i     (wr_index),
    .wr_word_i      (wr_word),
    .wr_data_i      (mem_rdata_i),
    .rd_word_addr_i (rd_word_addr),
    .rd_word_o      (rd_word),
    .rd_next_word_o (rd_next_word)
  );

  icache_align u_align (
    .offset_i     (lookup_offset),
    .word_i       (rd_word),
    .next_word_i  (rd_next_word),
    .inst_o       (inst),
    .cross_line_o (cross_line)
  );

  icache_csr u_csr (
    .clk          (clk),
    .rst          (rst),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .hit_pulse_i  (hit_pulse),
    .miss_pulse_i (miss_pulse),
    .flush_ack_i  (flush),
    .flush_req_o  (flush_req),
    .unc_base_o   (unc_base),
    .unc_mask_o   (unc_mask)
  );

endmodule

//--- icache_top.f
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_align.sv
hw/icache_csr.sv
hw/icache_top.sv
verif/icache_assert.sv
verif/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the icache testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module icache_tb -Mdir "$OBJ" -f icache_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vicache_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

//--- verif/icache_assert.sv
`timescale 1ns/1ps

module icache_assert (
  input logic        clk,
  input logic        rst,
  input logic        mem_req_valid_i,
  input logic [31:0] mem_addr_i,
  input logic        fetch_rvalid_i
);

  // no memory request until reset, idle and lookup have passed
  a_req_low_after_rst: assert property (@(posedge clk) $past(rst, 3) |-> !mem_req_valid_i)
    else $error("memory request active too soon after reset");

  // address held for the whole burst
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_i && $past(mem_req_valid_i) |-> $stable(mem_addr_i))
    else $error("mem_addr_o changed while a request was pending");

  // response only once the memory side is quiet
  a_no_rvalid_in_req: assert property (@(posedge clk) disable iff (rst)
    !(fetch_rvalid_i && mem_req_valid_i))
    else $error("fetch_rvalid_o high while mem_req_valid_o is high");

endmodule

bind icache_top icache_assert u_assert (
  .clk             (clk),
  .rst             (rst),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_addr_i      (mem_addr_o),
  .fetch_rvalid_i  (fetch_rvalid_o)
);

//--- verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

  // table operations
  localparam int OP_FETCH = 0;
  localparam int OP_WRITE = 1;
  localparam int OP_FLUSH = 2;

  localparam int MODEL_WORDS   = 4096;
  localparam int FETCH_TIMEOUT = 2000;

  logic        clk;
  logic        rst;
  logic        fetch_valid_i;
  logic [31:0] fetch_addr_i;
  logic        fetch_rvalid_o;
  logic [31:0] fetch_rdata_o;
  logic        mem_req_valid_o;
  logic [31:0] mem_addr_o;
  logic [7:0]  mem_len_o;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [4:0]  paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;

  // memory model, 16 KB aliased over the whole address space
  logic [31:0] model_mem [MODEL_WORDS];
  integer      seed;
  logic        busy;
  logic [31:0] burst_base;
  logic [31:0] beat_addr;
  logic [7:0]  burst_len;
  logic [7:0]  beat;
  int          gap;
  int          burst_cnt;

  // requests the fetch in flight should cause, in order
  logic [31:0] exp_addr_q [$];
  logic [7:0]  exp_len_q [$];

  // expected cache contents and counters
  logic        line_valid [128];
  logic [25:0] line_addr [128];
  logic [31:0] unc_base;
  logic [31:0] unc_mask;
  int          hit_exp;
  int          miss_exp;

  // stimulus table
  int          tab_op [$];
  logic [31:0] tab_addr [$];
  logic [31:0] tab_data [$];

  icache_top u_icache_top (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_rvalid_o  (fetch_rvalid_o),
    .fetch_rdata_o   (fetch_rdata_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_addr_o      (mem_addr_o),
    .mem_len_o       (mem_len_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  // burst server, random gap of 0..3 cycles before each beat
  always @(negedge clk) begin
    mem_rvalid_i = 1'b0;
    if (!busy && mem_req_valid_o) begin
      busy       = 1'b1;
      burst_base = mem_addr_o;
      burst_len  = mem_len_o;
      beat       = 8'd0;
      gap        = $unsigned($random(seed)) % 4;
      burst_cnt++;
      // address and length of each request
      if (exp_addr_q.size() == 0) begin
        $display("memory request to 0x%08h that no fetch needs", mem_addr_o);
        abort_run();
      end else begin
        check_value("mem_addr_o", mem_addr_o, exp_addr_q.pop_front());
        check_value("mem_len_o", {24'd0, mem_len_o}, {24'd0, exp_len_q.pop_front()});
      end
    end
    if (busy) begin
      if (gap > 0) begin
        gap--;
      end else begin
        beat_addr    = burst_base + {22'd0, beat, 2'b00};
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = model_mem[beat_addr[13:2]];
        if (beat == burst_len) begin
          busy = 1'b0;
        end else begin
          beat = beat + 8'd1;
          gap  = $unsigned($random(seed)) % 4;
        end
      end
    end
  end

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    logic [31:0] w;
    w = model_mem[addr[13:2]];
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  // rvc rule: low bits 11 mean 32-bit, zero result becomes a nop
  function automatic logic [31:0] expected_inst(input logic [31:0] addr);
    logic [15:0] lo;
    logic [31:0] inst;
    lo = half_at(addr);
    if (lo[1:0] == 2'b11) begin
      inst = {half_at(addr + 32'd2), lo};
    end else begin
      inst = {16'h0000, lo};
    end
    if (inst == 32'h0) begin
      inst = 32'h0000_0013;
    end
    return inst;
  endfunction

  function automatic logic resident(input logic [31:0] addr);
    return line_valid[addr[12:6]] && (line_addr[addr[12:6]] == addr[31:6]);
  endfunction

  task automatic mark_line(input logic [31:0] addr);
    line_valid[addr[12:6]] = 1'b1;
    line_addr[addr[12:6]]  = addr[31:6];
  endtask

  task automatic expect_request(input logic [31:0] addr, input logic [7:0] len);
    exp_addr_q.push_back(addr);
    exp_len_q.push_back(len);
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    @(negedge clk);
    penable_i = 1'b1;
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    @(negedge clk);
    penable_i = 1'b1;
    // zero-wait, prdata valid in the access phase
    data = prdata_o;
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic run_fetch(input logic [31:0] addr);
    logic        cached;
    logic [15:0] lo;
    logic [31:0] next_addr;
    logic [31:0] rdata;
    logic [31:0] cnt;
    int          refills;
    int          bursts_before;
    int          cycles;
    cached        = (addr & unc_mask) != unc_base;
    lo            = half_at(addr);
    next_addr     = addr + 32'd2;
    refills       = 0;
    bursts_before = burst_cnt;
    if (cached) begin
      if (!resident(addr)) begin
        mark_line(addr);
        expect_request({addr[31:6], 6'd0}, 8'd15);
        refills++;
      end
      // 32-bit start at byte 62 needs the next line too
      if (lo[1:0] == 2'b11 && addr[5:1] == 5'h1F && !resident(next_addr)) begin
        mark_line(next_addr);
        expect_request({next_addr[31:6], 6'd0}, 8'd15);
        refills++;
      end
    end else begin
      // one word-aligned beat
      expect_request({addr[31:2], 2'b00}, 8'd0);
    end
    @(negedge clk);
    fetch_valid_i = 1'b1;
    fetch_addr_i  = addr;
    cycles        = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > FETCH_TIMEOUT) begin
        $display("no fetch response from the cache for address 0x%08h", addr);
        abort_run();
      end
    end while (!fetch_rvalid_o);
    rdata         = fetch_rdata_o;
    fetch_valid_i = 1'b0;
    if (cached) begin
      check_value("fetch_rdata_o", rdata, expected_inst(addr));
      check_value("refill count", 32'(burst_cnt - bursts_before), 32'(refills));
      if (refills == 0) begin
        check_value("hit latency", 32'(cycles), 32'd2);
      end
      hit_exp++;
      miss_exp += refills;
    end else begin
      // raw word, no alignment and no nop
      check_value("fetch_rdata_o", rdata, model_mem[addr[13:2]]);
      check_value("uncached reads", 32'(burst_cnt - bursts_before), 32'd1);
    end
    apb_read(icache_pkg::HIT_CNT, cnt);
    check_value("HIT_CNT", cnt, 32'(hit_exp));
    apb_read(icache_pkg::MISS_CNT, cnt);
    check_value("MISS_CNT", cnt, 32'(miss_exp));
  endtask

  task automatic run_csr_write(input logic [4:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    apb_write(addr, data);
    apb_read(addr, rd);
    check_value("prdata_o", rd, data);
    if (addr == icache_pkg::UNC_BASE) begin
      unc_base = data;
    end else if (addr == icache_pkg::UNC_MASK) begin
      unc_mask = data;
    end
  endtask

  task automatic run_flush();
    logic [31:0] rd;
    int          i;
    apb_write(icache_pkg::CTRL, 32'd1);
    apb_read(icache_pkg::CTRL, rd);
    check_value("CTRL", rd, 32'd0);
    for (i = 0; i < 128; i++) begin
      line_valid[i] = 1'b0;
    end
  endtask

  task automatic add_row(input int op, input logic [31:0] addr, input logic [31:0] data);
    tab_op.push_back(op);
    tab_addr.push_back(addr);
    tab_data.push_back(data);
  endtask

  task automatic load_table();
    // cold miss, then hits in the same line
    add_row(OP_FETCH, 32'h0000_0100, 32'h0);
    add_row(OP_FETCH, 32'h0000_0102, 32'h0);
    add_row(OP_FETCH, 32'h0000_0104, 32'h0);
    add_row(OP_FETCH, 32'h0000_010A, 32'h0);
    // demand refill plus next-line refill, then next line hits
    add_row(OP_FETCH, 32'h0000_043E, 32'h0);
    add_row(OP_FETCH, 32'h0000_0440, 32'h0);
    // zero word
    add_row(OP_FETCH, 32'h0000_0200, 32'h0);
    add_row(OP_FETCH, 32'h0000_0202, 32'h0);
    // reset uncached window
    add_row(OP_FETCH, 32'hA000_0104, 32'h0);
    add_row(OP_FETCH, 32'hA000_0106, 32'h0);
    // move the window to 0x800..0xfff
    add_row(OP_WRITE, {27'd0, icache_pkg::UNC_BASE}, 32'h0000_0800);
    add_row(OP_WRITE, {27'd0, icache_pkg::UNC_MASK}, 32'hFFFF_F800);
    add_row(OP_FETCH, 32'h0000_0804, 32'h0);
    // now cached, evicts line 0x100 at index 4
    add_row(OP_FETCH, 32'hA000_0104, 32'h0);
    add_row(OP_FETCH, 32'h0000_0104, 32'h0);
    add_row(OP_FETCH, 32'h0000_043C, 32'h0);
    // fence.i
    add_row(OP_FLUSH, 32'h0, 32'h0);
    add_row(OP_FETCH, 32'h0000_0104, 32'h0);
    add_row(OP_FETCH, 32'h0000_0106, 32'h0);
    // demand line present, next line absent
    add_row(OP_FETCH, 32'h0000_013E, 32'h0);
    add_row(OP_FETCH, 32'h0000_043E, 32'h0);
  endtask

  initial begin
    int i;
    seed          = 65;
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = 32'h0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = 32'h0;
    psel_i        = 1'b0;
    penable_i     = 1'b0;
    pwrite_i      = 1'b0;
    paddr_i       = 5'h0;
    pwdata_i      = 32'h0;
    busy          = 1'b0;
    burst_cnt     = 0;
    hit_exp       = 0;
    miss_exp      = 0;
    unc_base      = 32'hA000_0000;
    unc_mask      = 32'hF000_0000;
    for (i = 0; i < MODEL_WORDS; i++) begin
      model_mem[i] = $random(seed);
    end
    for (i = 0; i < 128; i++) begin
      line_valid[i] = 1'b0;
      line_addr[i]  = 26'd0;
    end
    // planted words: zero at 0x200, compressed at 0x100
    model_mem[12'h080] = 32'h0;
    model_mem[12'h040] = model_mem[12'h040] & 32'hFFFF_FFFC;
    // 32-bit at 0x104 and 0x10a
    model_mem[12'h041] = model_mem[12'h041] | 32'h0000_0003;
    model_mem[12'h042] = model_mem[12'h042] | 32'h0003_0000;
    // 32-bit starting at byte 62 of lines 0x400 and 0x100
    model_mem[12'h10F] = model_mem[12'h10F] | 32'h0003_0000;
    model_mem[12'h04F] = model_mem[12'h04F] | 32'h0003_0000;
    load_table();
    repeat (5) @(negedge clk);
    rst = 1'b0;
    for (i = 0; i < tab_op.size(); i++) begin
      case (tab_op[i])
        OP_FETCH: run_fetch(tab_addr[i]);
        OP_WRITE: run_csr_write(tab_addr[i][4:0], tab_data[i]);
        default:  run_flush();
      endcase
    end
    repeat (4) @(negedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule
